//--- include/mcpu_settings.svh
`ifndef MCPU_SETTINGS_SVH
`define MCPU_SETTINGS_SVH

// Packet shape
`define MCPU_LANES      4   // Instructions per fetch packet
`define MCPU_INST_W     32  // One instruction

// Datapath
`define MCPU_DATA_W     32  // Register width
`define MCPU_REG_COUNT  32  // Architectural registers, r0 reads zero
`define MCPU_VPC_W      28  // Packet index, byte address bits 31:4
`define MCPU_IMM_W      12  // Zero-extended immediate

`endif

//--- hdl/mcpu_pkg.sv
`include "mcpu_settings.svh"

package mcpu_pkg;

  typedef logic [$clog2(`MCPU_REG_COUNT)-1:0] reg_num_t;  // 5 bits
  typedef logic [`MCPU_DATA_W-1:0]            data_t;
  typedef logic [`MCPU_VPC_W-1:0]             vpc_t;      // Packet PC
  typedef logic [`MCPU_INST_W-1:0]            inst_t;
  typedef inst_t [`MCPU_LANES-1:0]            packet_t;   // Lane 0 in low word

  typedef enum logic [3:0] {
    OP_NOP = 4'd0,
    OP_ADD = 4'd1,
    OP_SUB = 4'd2,
    OP_AND = 4'd3,
    OP_OR  = 4'd4,
    OP_XOR = 4'd5,
    OP_SHL = 4'd6,
    OP_SHR = 4'd7   // Logical; codes 8..15 invalid
  } alu_op_e;

  // Instruction layout, op in the top nibble
  typedef struct packed {
    logic [3:0]            op;       // Raw, may be invalid
    reg_num_t              rd;
    reg_num_t              rs;
    reg_num_t              rt;
    logic                  imm_sel;  // Second operand from imm
    logic [`MCPU_IMM_W-1:0] imm;
  } inst_fields_t;

  typedef struct packed {
    alu_op_e                op;
    reg_num_t               rd_num;
    logic                   rd_we;
    logic                   imm_sel;
    logic [`MCPU_IMM_W-1:0] imm;
    data_t                  rs_data;
    data_t                  rt_data;
  } ex_lane_t;

  typedef struct packed {
    packet_t packet;
    vpc_t    pc;
  } f2d_t;                                       // 156 bits

  typedef ex_lane_t [`MCPU_LANES-1:0] d2pc_t;

  typedef struct packed {
    logic     we;
    reg_num_t rd_num;
    data_t    data;
  } wb_lane_t;                                   // 38 bits

  typedef wb_lane_t [`MCPU_LANES-1:0] pc2wb_t;

endpackage

//--- hdl/mcpu_wb_if.sv
`timescale 1ns/1ns

// Writeback bundle, always accepted
interface mcpu_wb_if;

  logic             valid;  // Writeback register occupied
  mcpu_pkg::pc2wb_t lanes;  // Per lane we, rd, result

  modport source (
    output valid,
    output lanes
  );

  modport sink (
    input valid,
    input lanes
  );

endinterface

//--- hdl/mcpu_pipe_reg.sv
`timescale 1ns/1ns

module mcpu_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clkrst_core_clk,
  input  logic     rst_n,
  input  logic     en,        // Stage can accept
  input  logic     valid_d,
  input  payload_t data_d,
  output logic     valid_q,
  output payload_t data_q
);

  always_ff @(posedge clkrst_core_clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;         // Empty stage
    end else if (en) begin
      valid_q <= valid_d;      // Bubble when upstream has nothing
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (en) begin
      data_q <= data_d;        // Payload, no reset
    end
  end

  // Upstream must hand over clean payload with every valid
  a_payload_known: assert property (@(posedge clkrst_core_clk) disable iff (!rst_n)
    valid_q |-> !$isunknown(data_q));

endmodule

//--- hdl/mcpu_fetch.sv
`timescale 1ns/1ns

module mcpu_fetch (
  input  logic               clkrst_core_clk,
  input  logic               rst_n,
  input  logic               take,         // Decode accepts held packet
  output mcpu_pkg::vpc_t     f2ic_paddr,
  output logic               f2ic_valid,
  input  mcpu_pkg::packet_t  ic2f_packet,
  input  logic               ic2f_ready,
  output logic               f2d_ready,
  output mcpu_pkg::f2d_t     f2d_data
);

  mcpu_pkg::vpc_t    pc;      // Packet PC, no branches
  mcpu_pkg::packet_t held;    // Captured I$ packet
  logic              full;    // Held packet waiting for decode
  logic              capture;

  assign capture = f2ic_valid && ic2f_ready;

  always_ff @(posedge clkrst_core_clk) begin
    if (!rst_n) begin
      pc   <= '0;                          // First request at PC 0
      full <= 1'b0;
    end else if (take) begin
      pc   <= pc + mcpu_pkg::vpc_t'(1);    // Next packet only after handoff
      full <= 1'b0;
    end else if (capture) begin
      full <= 1'b1;
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (capture) begin
      held <= ic2f_packet;
    end
  end

  assign f2ic_valid = rst_n && !full;      // Request while buffer empty, idle in reset
  assign f2ic_paddr = pc;                  // Physical equals packet PC
  assign f2d_ready  = full;

  always_comb begin
    f2d_data.packet = held;
    f2d_data.pc     = pc;                  // PC moves only on take
  end

  // Level handshake: request held steady until the I$ answers
  a_req_stable: assert property (@(posedge clkrst_core_clk) disable iff (!rst_n)
    f2ic_valid && !ic2f_ready |=> f2ic_valid && $stable(f2ic_paddr));

endmodule

//--- hdl/mcpu_decode.sv
`timescale 1ns/1ns
`include "mcpu_settings.svh"

module mcpu_decode (
  input  mcpu_pkg::inst_t              inst,
  input  logic [`MCPU_REG_COUNT-1:0]   pending,   // Scoreboard bits
  output mcpu_pkg::reg_num_t           rs_num,
  output mcpu_pkg::reg_num_t           rt_num,
  input  mcpu_pkg::data_t              rs_data,
  input  mcpu_pkg::data_t              rt_data,
  output mcpu_pkg::ex_lane_t           lane,
  output logic                         stall
);

  mcpu_pkg::inst_fields_t f;
  logic                   op_ok;     // Codes 0..7
  logic                   active;    // Real ALU op
  logic                   rt_used;
  logic                   rd_we;

  assign f       = inst;
  assign op_ok   = !f.op[3];                              // Top half of space unused
  assign active  = op_ok && (f.op != mcpu_pkg::OP_NOP);
  assign rt_used = active && !f.imm_sel;
  assign rd_we   = active && (f.rd != '0);                // r0 never written

  // Register file read addresses straight from the fields
  assign rs_num = f.rs;
  assign rt_num = f.rt;

  always_comb begin
    lane.op      = active ? mcpu_pkg::alu_op_e'(f.op) : mcpu_pkg::OP_NOP;
    lane.rd_num  = f.rd;
    lane.rd_we   = rd_we;
    lane.imm_sel = f.imm_sel;
    lane.imm     = f.imm;
    lane.rs_data = rs_data;       // Values from before this packet
    lane.rt_data = rt_data;
  end

  // RAW on sources, WAW on the destination
  assign stall = (active && pending[f.rs])
              || (rt_used && pending[f.rt])
              || (rd_we && pending[f.rd]);

endmodule

//--- hdl/mcpu_regfile.sv
`timescale 1ns/1ns
`include "mcpu_settings.svh"

module mcpu_regfile (
  input  logic               clkrst_core_clk,
  input  logic               rst_n,
  input  mcpu_pkg::reg_num_t rs_num  [`MCPU_LANES],
  input  mcpu_pkg::reg_num_t rt_num  [`MCPU_LANES],
  output mcpu_pkg::data_t    rs_data [`MCPU_LANES],
  output mcpu_pkg::data_t    rt_data [`MCPU_LANES],
  mcpu_wb_if.sink            wb
);

  mcpu_pkg::data_t regs [`MCPU_REG_COUNT];

  always_ff @(posedge clkrst_core_clk) begin
    if (!rst_n) begin
      for (int r = 0; r < `MCPU_REG_COUNT; r++) begin
        regs[r] <= '0;                            // Architectural reset state
      end
    end else if (wb.valid) begin
      for (int i = 0; i < `MCPU_LANES; i++) begin
        if (wb.lanes[i].we) begin
          regs[wb.lanes[i].rd_num] <= wb.lanes[i].data;
        end
      end
    end
  end

  // Four read pairs, no bypass; scoreboard covers in-flight writes
  always_comb begin
    for (int i = 0; i < `MCPU_LANES; i++) begin
      rs_data[i] = regs[rs_num[i]];
      rt_data[i] = regs[rt_num[i]];
    end
  end

  // Decode never lets one packet write a register twice
  for (genvar a = 0; a < `MCPU_LANES; a++) begin : g_wr_a
    for (genvar b = a + 1; b < `MCPU_LANES; b++) begin : g_wr_b
      a_no_dup_write: assert property (@(posedge clkrst_core_clk) disable iff (!rst_n)
        wb.valid && wb.lanes[a].we && wb.lanes[b].we
          |-> wb.lanes[a].rd_num != wb.lanes[b].rd_num);
    end
  end

endmodule

//--- hdl/mcpu_scoreboard.sv
`timescale 1ns/1ns
`include "mcpu_settings.svh"

module mcpu_scoreboard (
  input  logic                       clkrst_core_clk,
  input  logic                       rst_n,
  input  logic                       issue,        // Decode progress
  input  mcpu_pkg::d2pc_t            issue_lanes,
  mcpu_wb_if.sink                    wb,
  output logic [`MCPU_REG_COUNT-1:0] pending
);

  logic [`MCPU_REG_COUNT-1:0] set_mask;   // Destinations issued now
  logic [`MCPU_REG_COUNT-1:0] clr_mask;   // Destinations written back now

  always_comb begin
    set_mask = '0;
    clr_mask = '0;
    for (int i = 0; i < `MCPU_LANES; i++) begin
      if (issue && issue_lanes[i].rd_we) begin
        set_mask[issue_lanes[i].rd_num] = 1'b1;
      end
      if (wb.valid && wb.lanes[i].we) begin
        clr_mask[wb.lanes[i].rd_num] = 1'b1;
      end
    end
  end

  always_ff @(posedge clkrst_core_clk) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr_mask) | set_mask;   // Set wins
    end
  end

  // Dependency stall in decode keeps issue off busy registers
  a_issue_free: assert property (@(posedge clkrst_core_clk) disable iff (!rst_n)
    issue |-> (set_mask & pending) == '0);

endmodule

//--- hdl/mcpu_alu.sv
`timescale 1ns/1ns

module mcpu_alu (
  input  mcpu_pkg::ex_lane_t lane,
  output mcpu_pkg::wb_lane_t result
);

  mcpu_pkg::data_t opb;   // Second operand
  mcpu_pkg::data_t value;

  // Immediate zero-extended to register width
  assign opb = lane.imm_sel ? mcpu_pkg::data_t'(lane.imm) : lane.rt_data;

  always_comb begin
    case (lane.op)
      mcpu_pkg::OP_ADD: value = lane.rs_data + opb;
      mcpu_pkg::OP_SUB: value = lane.rs_data - opb;
      mcpu_pkg::OP_AND: value = lane.rs_data & opb;
      mcpu_pkg::OP_OR:  value = lane.rs_data | opb;
      mcpu_pkg::OP_XOR: value = lane.rs_data ^ opb;
      mcpu_pkg::OP_SHL: value = lane.rs_data << opb[4:0];   // Low 5 bits only
      mcpu_pkg::OP_SHR: value = lane.rs_data >> opb[4:0];   // Logical
      default:          value = '0;                         // NOP, result dropped
    endcase
  end

  always_comb begin
    result.we     = lane.rd_we;
    result.rd_num = lane.rd_num;
    result.data   = value;
  end

endmodule

//--- hdl/mcpu_core.sv
`timescale 1ns/1ns
`include "mcpu_settings.svh"

module mcpu_core (
  input  logic                                    clkrst_core_clk,
  input  logic                                    rst_n,
  output mcpu_pkg::vpc_t                          f2ic_paddr,
  output logic                                    f2ic_valid,
  input  mcpu_pkg::packet_t                       ic2f_packet,
  input  logic                                    ic2f_ready,
  output logic                                    retire_valid,
  output logic [`MCPU_LANES-1:0]                  retire_we,
  output mcpu_pkg::reg_num_t [`MCPU_LANES-1:0]    retire_rd_num,
  output mcpu_pkg::data_t [`MCPU_LANES-1:0]       retire_rd_data
);

  // Stage status
  logic f_ready;                        // Fetch holds a packet
  logic dcd_valid, pc_valid;
  logic f2d_readyin, f2d_progress;
  logic d2pc_readyin, d2pc_readyout, d2pc_progress;
  logic pc2wb_progress;
  logic dcd_depstall;
  logic [`MCPU_LANES-1:0] lane_stall;

  // Stage payloads
  mcpu_pkg::f2d_t   f2d_out, f2d_in;
  mcpu_pkg::d2pc_t  d2pc_out, d2pc_in;
  mcpu_pkg::pc2wb_t pc2wb_out;

  // Register file and scoreboard links
  mcpu_pkg::reg_num_t         rs_num  [`MCPU_LANES];
  mcpu_pkg::reg_num_t         rt_num  [`MCPU_LANES];
  mcpu_pkg::data_t            rs_data [`MCPU_LANES];
  mcpu_pkg::data_t            rt_data [`MCPU_LANES];
  logic [`MCPU_REG_COUNT-1:0] pending;

  mcpu_wb_if wb ();

  assign f2d_readyin    = !dcd_valid || d2pc_progress;
  assign f2d_progress   = f_ready && f2d_readyin;

  assign dcd_depstall   = |lane_stall;                    // All lanes or none
  assign d2pc_readyin   = !pc_valid || pc2wb_progress;
  assign d2pc_readyout  = dcd_valid && !dcd_depstall;
  assign d2pc_progress  = d2pc_readyout && d2pc_readyin;

  assign pc2wb_progress = pc_valid;     // Single-cycle execute, writeback always accepts

  mcpu_fetch fetch (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .take            (f2d_progress),
    .f2ic_paddr      (f2ic_paddr),
    .f2ic_valid      (f2ic_valid),
    .ic2f_packet     (ic2f_packet),
    .ic2f_ready      (ic2f_ready),
    .f2d_ready       (f_ready),
    .f2d_data        (f2d_out)
  );

  mcpu_pipe_reg #(.payload_t(mcpu_pkg::f2d_t)) f2d_reg (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .en              (f2d_readyin),
    .valid_d         (f_ready),
    .data_d          (f2d_out),
    .valid_q         (dcd_valid),
    .data_q          (f2d_in)
  );

  for (genvar i = 0; i < `MCPU_LANES; i++) begin : g_lane
    mcpu_decode dcd (
      .inst    (f2d_in.packet[i]),
      .pending (pending),
      .rs_num  (rs_num[i]),
      .rt_num  (rt_num[i]),
      .rs_data (rs_data[i]),
      .rt_data (rt_data[i]),
      .lane    (d2pc_out[i]),
      .stall   (lane_stall[i])
    );

    mcpu_alu alu (
      .lane   (d2pc_in[i]),
      .result (pc2wb_out[i])
    );

    assign retire_we[i]      = wb.lanes[i].we;
    assign retire_rd_num[i]  = wb.lanes[i].rd_num;
    assign retire_rd_data[i] = wb.lanes[i].data;
  end

  mcpu_regfile regs (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .rs_num          (rs_num),
    .rt_num          (rt_num),
    .rs_data         (rs_data),
    .rt_data         (rt_data),
    .wb              (wb.sink)
  );

  mcpu_scoreboard sb (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .issue           (d2pc_progress),
    .issue_lanes     (d2pc_out),
    .wb              (wb.sink),
    .pending         (pending)
  );

  mcpu_pipe_reg #(.payload_t(mcpu_pkg::d2pc_t)) d2pc_reg (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .en              (d2pc_readyin),
    .valid_d         (d2pc_readyout),     // Bubble on stall
    .data_d          (d2pc_out),
    .valid_q         (pc_valid),
    .data_q          (d2pc_in)
  );

  // Drives the writeback bundle seen by regfile and scoreboard
  mcpu_pipe_reg #(.payload_t(mcpu_pkg::pc2wb_t)) pc2wb_reg (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .en              (1'b1),
    .valid_d         (pc2wb_progress),
    .data_d          (pc2wb_out),
    .valid_q         (wb.valid),
    .data_q          (wb.lanes)
  );

  assign retire_valid = wb.valid;         // Retire equals writeback

endmodule

//--- test/tb_mcpu_core.sv
`timescale 1ns/1ns
`include "mcpu_settings.svh"

module tb_mcpu_core;

  localparam int ROWS       = 11;                     // Program packets with expected retires
  localparam int TIMEOUT_NS = (4 + ROWS * 40) * 10;   // 40 cycles per row plus reset

  logic                                         clkrst_core_clk;
  logic                                         rst_n;
  mcpu_pkg::vpc_t                               f2ic_paddr;
  logic                                         f2ic_valid;
  mcpu_pkg::packet_t                            ic2f_packet;
  logic                                         ic2f_ready;
  logic                                         retire_valid;
  logic [`MCPU_LANES-1:0]                       retire_we;
  mcpu_pkg::reg_num_t [`MCPU_LANES-1:0]         retire_rd_num;
  mcpu_pkg::data_t [`MCPU_LANES-1:0]            retire_rd_data;

  // Program table and expected retire lanes
  mcpu_pkg::packet_t      prog     [ROWS];
  logic [`MCPU_LANES-1:0] exp_we   [ROWS];
  mcpu_pkg::reg_num_t     exp_rd   [ROWS][`MCPU_LANES];
  mcpu_pkg::data_t        exp_data [ROWS][`MCPU_LANES];

  int             errors;      // All failed checks
  int             fetch_errs;  // Request address failures
  int             checks;
  int             row_idx;     // Next expected retire row
  int             served;      // Packets handed out by the I$ model
  int             delay;       // I$ wait cycles left, -1 when idle
  int             addr;
  logic           in_reset;
  mcpu_pkg::vpc_t req_addr;    // Address seen at request start

  mcpu_core mcpu_core_i (
    .clkrst_core_clk (clkrst_core_clk),
    .rst_n           (rst_n),
    .f2ic_paddr      (f2ic_paddr),
    .f2ic_valid      (f2ic_valid),
    .ic2f_packet     (ic2f_packet),
    .ic2f_ready      (ic2f_ready),
    .retire_valid    (retire_valid),
    .retire_we       (retire_we),
    .retire_rd_num   (retire_rd_num),
    .retire_rd_data  (retire_rd_data)
  );

  always #5 clkrst_core_clk = ~clkrst_core_clk;

  // One lane of the table: encode the instruction and store its expected retire
  task automatic put_lane(input int row, input int lane, input logic [3:0] op, input int rd,
                          input int rs, input int rt, input int isel, input int imm,
                          input int we, input logic [31:0] data);
    prog[row][lane]     = {op, mcpu_pkg::reg_num_t'(rd), mcpu_pkg::reg_num_t'(rs),
                           mcpu_pkg::reg_num_t'(rt), isel[0], 12'(imm)};
    exp_we[row][lane]   = we[0];
    exp_rd[row][lane]   = mcpu_pkg::reg_num_t'(rd);
    exp_data[row][lane] = data;
  endtask

  task automatic load_program();
    for (int r = 0; r < ROWS; r++) begin
      prog[r]   = '0;                                // Unfilled rows stay NOP packets
      exp_we[r] = '0;
    end
    // Load constants through r0 plus immediate
    put_lane(0, 0, mcpu_pkg::OP_ADD,  1,  0,  0, 1, 'h123, 1, 32'h0000_0123);
    put_lane(0, 1, mcpu_pkg::OP_ADD,  2,  0,  0, 1, 'h0f0, 1, 32'h0000_00f0);
    put_lane(0, 2, mcpu_pkg::OP_ADD,  3,  0,  0, 1, 'hfff, 1, 32'h0000_0fff);
    put_lane(0, 3, mcpu_pkg::OP_ADD,  4,  0,  0, 1, 'h005, 1, 32'h0000_0005);
    // Reads the packet just before, so decode stalls
    put_lane(1, 0, mcpu_pkg::OP_ADD,  5,  1,  2, 0, 'h000, 1, 32'h0000_0213);
    put_lane(1, 1, mcpu_pkg::OP_SUB,  6,  2,  1, 0, 'h000, 1, 32'hffff_ffcd);
    put_lane(1, 2, mcpu_pkg::OP_AND,  7,  3,  1, 0, 'h000, 1, 32'h0000_0123);
    put_lane(1, 3, mcpu_pkg::OP_OR,   8,  2,  4, 0, 'h000, 1, 32'h0000_00f5);
    put_lane(2, 0, mcpu_pkg::OP_XOR,  9,  3,  2, 0, 'h000, 1, 32'h0000_0f0f);
    put_lane(2, 1, mcpu_pkg::OP_SUB, 10,  4,  3, 0, 'h000, 1, 32'hffff_f006);
    put_lane(2, 2, mcpu_pkg::OP_AND, 11,  2,  4, 0, 'h000, 1, 32'h0000_0000);
    put_lane(2, 3, mcpu_pkg::OP_OR,  12,  1,  4, 0, 'h000, 1, 32'h0000_0127);
    put_lane(3, 0, mcpu_pkg::OP_ADD, 13,  9, 10, 0, 'h000, 1, 32'hffff_ff15);
    put_lane(3, 1, mcpu_pkg::OP_XOR, 14, 12,  5, 0, 'h000, 1, 32'h0000_0334);
    put_lane(3, 2, mcpu_pkg::OP_SUB, 15, 11,  4, 0, 'h000, 1, 32'hffff_fffb);
    put_lane(3, 3, mcpu_pkg::OP_OR,  16,  6,  0, 0, 'h000, 1, 32'hffff_ffcd);
    // Immediate forms, immediate zero-extended, shift by low 5 bits
    put_lane(4, 0, mcpu_pkg::OP_SHL, 17,  1,  0, 1, 'h004, 1, 32'h0000_1230);
    put_lane(4, 1, mcpu_pkg::OP_SHR, 18,  6,  0, 1, 'h008, 1, 32'h00ff_ffff);
    put_lane(4, 2, mcpu_pkg::OP_XOR, 19,  3,  0, 1, 'h800, 1, 32'h0000_07ff);
    put_lane(4, 3, mcpu_pkg::OP_SHL, 20,  4,  0, 1, 'h021, 1, 32'h0000_000a);
    put_lane(5, 0, mcpu_pkg::OP_SHR, 21,  3,  4, 0, 'h000, 1, 32'h0000_007f);
    put_lane(5, 1, mcpu_pkg::OP_SHL, 22,  4,  9, 0, 'h000, 1, 32'h0002_8000);
    put_lane(5, 2, mcpu_pkg::OP_AND, 23,  6,  0, 1, 'hfff, 1, 32'h0000_0fcd);
    put_lane(5, 3, mcpu_pkg::OP_SUB, 24,  1,  0, 1, 'h124, 1, 32'hffff_ffff);
    // r0 target, NOP and invalid codes write nothing
    put_lane(6, 0, mcpu_pkg::OP_ADD,  0,  1,  0, 1, 'h001, 0, 32'h0);
    put_lane(6, 1, mcpu_pkg::OP_NOP, 25,  1,  2, 0, 'h000, 0, 32'h0);
    put_lane(6, 2, 4'd9,             26,  1,  0, 0, 'h000, 0, 32'h0);
    put_lane(6, 3, 4'd15,            28,  2,  0, 1, 'h0ff, 0, 32'h0);
    put_lane(7, 0, mcpu_pkg::OP_ADD, 25,  0,  0, 0, 'h000, 1, 32'h0000_0000);
    put_lane(7, 1, mcpu_pkg::OP_ADD, 26, 26,  0, 1, 'h007, 1, 32'h0000_0007);
    put_lane(7, 2, mcpu_pkg::OP_XOR, 27, 28,  0, 0, 'h000, 1, 32'h0000_0000);
    put_lane(7, 3, mcpu_pkg::OP_SUB, 29,  0,  0, 1, 'h001, 1, 32'hffff_ffff);
    // Row 8 all NOP
    put_lane(9, 0, mcpu_pkg::OP_ADD,  1,  1,  0, 1, 'h001, 1, 32'h0000_0124);
    put_lane(9, 1, mcpu_pkg::OP_ADD,  2,  1,  0, 1, 'h000, 1, 32'h0000_0123);  // Old r1
    put_lane(9, 2, mcpu_pkg::OP_SHR,  3,  3,  0, 1, 'h004, 1, 32'h0000_00ff);
    put_lane(9, 3, mcpu_pkg::OP_ADD,  4,  0,  0, 1, 'h7ff, 1, 32'h0000_07ff);
    put_lane(10, 0, mcpu_pkg::OP_ADD, 30,  1,  2, 0, 'h000, 1, 32'h0000_0247);
    put_lane(10, 1, mcpu_pkg::OP_SUB, 31,  3,  4, 0, 'h000, 1, 32'hffff_f900);
    put_lane(10, 2, mcpu_pkg::OP_SHL,  5,  4,  3, 0, 'h000, 1, 32'h8000_0000);
    put_lane(10, 3, mcpu_pkg::OP_AND,  6,  1,  2, 0, 'h000, 1, 32'h0000_0120);
  endtask

  task automatic check_row(input int row);
    int errs;
    errs = 0;
    for (int l = 0; l < `MCPU_LANES; l++) begin
      checks++;
      if (retire_we[l] !== exp_we[row][l]) begin
        $display("Mismatch at %0t: retire_we[%0d] got %b expected %b",
                 $time, l, retire_we[l], exp_we[row][l]);
        errs++;
      end else if (exp_we[row][l]) begin
        if (retire_rd_num[l] !== exp_rd[row][l]) begin
          $display("Mismatch at %0t: retire_rd_num[%0d] got %0d expected %0d",
                   $time, l, retire_rd_num[l], exp_rd[row][l]);
          errs++;
        end
        if (retire_rd_data[l] !== exp_data[row][l]) begin
          $display("Mismatch at %0t: retire_rd_data[%0d] got %h expected %h",
                   $time, l, retire_rd_data[l], exp_data[row][l]);
          errs++;
        end
      end
    end
    errors += errs;
    if (errs == 0) begin
      $display("row %0d retired, all lanes match", row);
    end else begin
      $display("row %0d retired with %0d errors", row, errs);
    end
  endtask

  // I$ model, random 0..3 cycle latency per request
  always @(posedge clkrst_core_clk) begin
    in_reset = !rst_n;                     // Stable since last drive
    #1;
    if (in_reset || !f2ic_valid) begin
      ic2f_ready = 1'b0;
      delay      = -1;
    end else begin
      if (delay < 0) begin                 // New request
        delay    = int'($urandom % 4);
        req_addr = f2ic_paddr;
        checks++;
        if (f2ic_paddr !== mcpu_pkg::vpc_t'(served)) begin
          $display("Mismatch at %0t: f2ic_paddr got %0d expected %0d",
                   $time, f2ic_paddr, served);
          fetch_errs++;
        end
      end else if (f2ic_paddr !== req_addr) begin
        $display("Mismatch at %0t: f2ic_paddr got %0d expected %0d while waiting",
                 $time, f2ic_paddr, req_addr);
        fetch_errs++;
      end
      if (delay == 0) begin
        addr        = int'(f2ic_paddr);
        ic2f_packet = (addr < ROWS) ? prog[addr] : '0;   // NOPs past the table
        ic2f_ready  = 1'b1;
        served++;
      end else begin
        delay--;
        ic2f_ready = 1'b0;
      end
    end
  end

  // Retire checker, each retire cycle takes the next row
  always @(posedge clkrst_core_clk) begin
    #1;
    if (retire_valid === 1'b1 && row_idx < ROWS) begin
      check_row(row_idx);
      row_idx++;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, %0d of %0d rows retired", TIMEOUT_NS, row_idx, ROWS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int reset_errs;
    void'($urandom(32'hcd64));
    clkrst_core_clk = 1'b0;
    rst_n           = 1'b0;
    ic2f_ready      = 1'b0;
    ic2f_packet     = '0;
    errors          = 0;
    fetch_errs      = 0;
    checks          = 0;
    row_idx         = 0;
    served          = 0;
    delay           = -1;
    reset_errs      = 0;
    load_program();
    for (int c = 0; c < 4; c++) begin      // Reset held 4 cycles
      @(posedge clkrst_core_clk);
      #1;
      checks++;
      if (retire_valid !== 1'b0) begin
        $display("Mismatch at %0t: retire_valid got %b expected 0", $time, retire_valid);
        reset_errs++;
      end
      if (f2ic_valid !== 1'b0) begin
        $display("Mismatch at %0t: f2ic_valid got %b expected 0", $time, f2ic_valid);
        reset_errs++;
      end
      if (f2ic_paddr !== '0) begin
        $display("Mismatch at %0t: f2ic_paddr got %0d expected 0", $time, f2ic_paddr);
        reset_errs++;
      end
    end
    rst_n  = 1'b1;
    errors += reset_errs;
    $display("reset: %0d errors", reset_errs);
    wait (row_idx == ROWS);
    errors += fetch_errs;
    $display("fetch: %0d packets served, %0d errors", served, fetch_errs);
    $display("%0d checks, %0d errors, %0d of %0d rows retired", checks, errors, row_idx, ROWS);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
hdl/mcpu_pkg.sv
hdl/mcpu_wb_if.sv
hdl/mcpu_pipe_reg.sv
hdl/mcpu_fetch.sv
hdl/mcpu_decode.sv
hdl/mcpu_regfile.sv
hdl/mcpu_scoreboard.sv
hdl/mcpu_alu.sv
hdl/mcpu_core.sv
test/tb_mcpu_core.sv

//--- run.sh
#!/bin/sh
# Build and run the mcpu_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_mcpu_core \
  --Mdir obj_dir -o tb_mcpu_core_sim \
  -f tb.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mcpu_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST OK" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
